// ==== soc_pkg.sv ====
`default_nettype none

package soc_pkg;

  // ==================================================
  // Widths
  // ==================================================
  localparam int unsigned XLEN = 32;
  localparam int unsigned BE_W = XLEN / 8;  // One enable per byte lane

  // ==================================================
  // Address map
  // ==================================================
  localparam logic [XLEN-1:0] RAM_BASE  = 32'h9000_0000;
  localparam int unsigned     RAM_WORDS = 256;
  localparam int unsigned     RAM_AW    = 8;           // Word address width of the scratchpad
  localparam int unsigned     RAM_LSB   = RAM_AW + 2;  // Lowest bit compared against RAM_BASE

  localparam logic [XLEN-1:0] GPIO_BASE = 32'h4000_0000;
  localparam int unsigned     GPIO_REGS = 4;
  localparam int unsigned     GPIO_AW   = $clog2(GPIO_REGS);
  localparam int unsigned     GPIO_LSB  = GPIO_AW + 2;  // 16 byte window
  localparam int unsigned     GPIO_W    = 4;            // Buttons, LEDs and interrupt lines

  // Word offsets inside the GPIO window
  localparam logic [GPIO_AW-1:0] GPIO_LED  = GPIO_AW'(0);  // Read and write
  localparam logic [GPIO_AW-1:0] GPIO_BTN  = GPIO_AW'(1);  // Synchronized buttons, read only
  localparam logic [GPIO_AW-1:0] GPIO_PEND = GPIO_AW'(2);  // Pending bits, write 1 to clear
  localparam logic [GPIO_AW-1:0] GPIO_EN   = GPIO_AW'(3);  // Interrupt enable mask

  // ==================================================
  // Bus types
  // ==================================================

  // Stage 2 target that a request was routed to
  typedef enum logic [1:0] {
    TGT_RAM  = 2'd0,
    TGT_GPIO = 2'd1,
    TGT_NONE = 2'd2
  } target_e;

  // Request from the core data port
  typedef struct packed {
    logic            valid;
    logic            we;
    logic [BE_W-1:0] be;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
  } bus_req_t;

  // Decoded request as seen by one peripheral
  typedef struct packed {
    logic              valid;
    logic              we;
    logic [BE_W-1:0]   be;
    logic [RAM_AW-1:0] word_addr;
    logic [XLEN-1:0]   wdata;
  } periph_req_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] rdata;  // Zero for writes
  } periph_resp_t;

  // Response back to the core, err marks an unmapped address
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] rdata;
    logic            err;
  } bus_resp_t;

endpackage

`default_nettype wire

// ==== bus_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module bus_decode (
  input  wire logic                  clk_i,
  input  wire logic                  anrst_i,
  input  wire soc_pkg::bus_req_t     req_i,
  output soc_pkg::periph_req_t       ram_req_o,
  output soc_pkg::periph_req_t       gpio_req_o,
  output soc_pkg::target_e           tgt_o
);

  import soc_pkg::*;

  logic              hit_ram;
  logic              hit_gpio;
  target_e           tgt_d;
  logic [RAM_AW-1:0] word_addr_d;

  logic              ram_vld_q;
  logic              gpio_vld_q;
  target_e           tgt_q;
  logic              we_q;
  logic [BE_W-1:0]   be_q;
  logic [RAM_AW-1:0] word_addr_q;
  logic [XLEN-1:0]   wdata_q;

  // ==================================================
  // Region decode
  // ==================================================
  assign hit_ram  = req_i.addr[XLEN-1:RAM_LSB]  == RAM_BASE[XLEN-1:RAM_LSB];
  assign hit_gpio = req_i.addr[XLEN-1:GPIO_LSB] == GPIO_BASE[XLEN-1:GPIO_LSB];

  always_comb begin
    tgt_d = TGT_RAM;  // Idle cycles park on the RAM, whose reply then stays invalid
    if (req_i.valid) begin
      if (hit_gpio)
        tgt_d = TGT_GPIO;
      else if (!hit_ram)
        tgt_d = TGT_NONE;
    end
  end

  // Byte offset bits 1:0 are dropped here
  assign word_addr_d = hit_gpio ? RAM_AW'(req_i.addr[GPIO_LSB-1:2])
                                : req_i.addr[RAM_LSB-1:2];

  // ==================================================
  // Stage 1 registers
  // ==================================================
  always_ff @(posedge clk_i, negedge anrst_i) begin
    if (!anrst_i) begin
      ram_vld_q  <= 1'b0;
      gpio_vld_q <= 1'b0;
      tgt_q      <= TGT_RAM;
    end else begin
      ram_vld_q  <= req_i.valid & hit_ram;
      gpio_vld_q <= req_i.valid & hit_gpio;
      tgt_q      <= tgt_d;
    end
  end

  // Payload is shared by both peripheral requests
  always_ff @(posedge clk_i) begin
    we_q        <= req_i.we;
    be_q        <= req_i.be;
    word_addr_q <= word_addr_d;
    wdata_q     <= req_i.wdata;
  end

  always_comb begin
    ram_req_o.valid      = ram_vld_q;
    ram_req_o.we         = we_q;
    ram_req_o.be         = be_q;
    ram_req_o.word_addr  = word_addr_q;
    ram_req_o.wdata      = wdata_q;
    gpio_req_o.valid     = gpio_vld_q;
    gpio_req_o.we        = we_q;
    gpio_req_o.be        = be_q;
    gpio_req_o.word_addr = word_addr_q;
    gpio_req_o.wdata     = wdata_q;
  end

  assign tgt_o = tgt_q;

  // Stage 2 never sees one request at two peripherals
  a_one_target: assert property (@(posedge clk_i) disable iff (!anrst_i)
    !(ram_req_o.valid && gpio_req_o.valid));

endmodule

`default_nettype wire

// ==== data_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module data_ram (
  input  wire logic                 clk_i,
  input  wire logic                 anrst_i,
  input  wire soc_pkg::periph_req_t req_i,
  output soc_pkg::periph_resp_t     resp_o
);

  import soc_pkg::*;

  logic [XLEN-1:0] mem [RAM_WORDS];
  logic            vld_q;
  logic [XLEN-1:0] rdata_q;

  // ==================================================
  // Storage with byte lanes
  // ==================================================

  // Each lane is written only when its enable is set
  always_ff @(posedge clk_i) begin
    if (req_i.valid && req_i.we) begin
      for (int b = 0; b < BE_W; b++) begin
        if (req_i.be[b])
          mem[req_i.word_addr][8*b +: 8] <= req_i.wdata[8*b +: 8];
      end
    end
  end

  // Registered read port
  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      if (req_i.we)
        rdata_q <= '0;  // Writes answer with zero data
      else
        rdata_q <= mem[req_i.word_addr];
    end
  end

  // ==================================================
  // Response valid
  // ==================================================
  always_ff @(posedge clk_i, negedge anrst_i) begin
    if (!anrst_i) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= req_i.valid;  // Every access gets exactly one reply
    end
  end

  always_comb begin
    resp_o.valid = vld_q;
    resp_o.rdata = rdata_q;
  end

  // An X in the word address would corrupt an unknown word
  a_addr_known: assert property (@(posedge clk_i) disable iff (!anrst_i)
    req_i.valid |-> !$isunknown(req_i.word_addr));

endmodule

`default_nettype wire

// ==== gpio_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module gpio_regs (
  input  wire logic                       clk_i,
  input  wire logic                       anrst_i,
  input  wire soc_pkg::periph_req_t       req_i,
  output soc_pkg::periph_resp_t           resp_o,
  input  wire logic [soc_pkg::GPIO_W-1:0] btn_i,
  output logic [soc_pkg::GPIO_W-1:0]      led_o,
  output logic                            irq_o,
  input  wire logic                       accept_i
);

  import soc_pkg::*;

  logic [GPIO_AW-1:0] offset;
  logic               wr_en;
  logic [GPIO_W-1:0]  btn_rise;
  logic [GPIO_W-1:0]  pend_clr;
  logic [XLEN-1:0]    rdata_d;

  logic [GPIO_W-1:0]  led_q;
  logic [GPIO_W-1:0]  btn_meta_q;
  logic [GPIO_W-1:0]  btn_sync_q;
  logic [GPIO_W-1:0]  btn_prev_q;
  logic [GPIO_W-1:0]  pend_q;
  logic [GPIO_W-1:0]  en_q;
  logic               vld_q;
  logic [XLEN-1:0]    rdata_q;

  assign offset = req_i.word_addr[GPIO_AW-1:0];
  assign wr_en  = req_i.valid & req_i.we & req_i.be[0];  // All fields sit in byte 0

  // ==================================================
  // Button synchronizer and edge detect
  // ==================================================
  always_ff @(posedge clk_i, negedge anrst_i) begin
    if (!anrst_i) begin
      btn_meta_q <= '0;
      btn_sync_q <= '0;
      btn_prev_q <= '0;
    end else begin
      btn_meta_q <= btn_i;
      btn_sync_q <= btn_meta_q;
      btn_prev_q <= btn_sync_q;  // Last value for the edge detector
    end
  end

  assign btn_rise = btn_sync_q & ~btn_prev_q;

  // Write of 1 clears a pending bit
  assign pend_clr = (wr_en && offset == GPIO_PEND) ? req_i.wdata[GPIO_W-1:0] : '0;

  // ==================================================
  // Register file
  // ==================================================
  always_ff @(posedge clk_i, negedge anrst_i) begin
    if (!anrst_i) begin
      led_q  <= '0;
      pend_q <= '0;
      en_q   <= '0;
    end else begin
      if (wr_en && offset == GPIO_LED)
        led_q <= req_i.wdata[GPIO_W-1:0];
      if (wr_en && offset == GPIO_EN)
        en_q <= req_i.wdata[GPIO_W-1:0];
      // A new edge wins over any clear in the same cycle
      if (accept_i)
        pend_q <= btn_rise;
      else
        pend_q <= (pend_q & ~pend_clr) | btn_rise;
    end
  end

  // Read mux over the four register words
  always_comb begin
    rdata_d = '0;
    if (!req_i.we) begin
      case (offset)
        GPIO_LED:  rdata_d[GPIO_W-1:0] = led_q;
        GPIO_BTN:  rdata_d[GPIO_W-1:0] = btn_sync_q;
        GPIO_PEND: rdata_d[GPIO_W-1:0] = pend_q;
        GPIO_EN:   rdata_d[GPIO_W-1:0] = en_q;
        default:   rdata_d = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i, negedge anrst_i) begin
    if (!anrst_i) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= req_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_q <= rdata_d;
  end

  always_comb begin
    resp_o.valid = vld_q;
    resp_o.rdata = rdata_q;
  end

  assign led_o = led_q;
  assign irq_o = |(pend_q & en_q);  // Stays high until the pending bits are cleared

  // The mask opens only through a write to the enable word
  a_irq_masked: assert property (@(posedge clk_i) disable iff (!anrst_i)
    $rose(irq_o) |-> $past((en_q != '0) || (wr_en && offset == GPIO_EN)));

endmodule

`default_nettype wire

// ==== resp_merge.sv ====
`timescale 1ns/10ps
`default_nettype none

module resp_merge (
  input  wire logic                  clk_i,
  input  wire logic                  anrst_i,
  input  wire soc_pkg::target_e      tgt_i,
  input  wire soc_pkg::periph_resp_t ram_resp_i,
  input  wire soc_pkg::periph_resp_t gpio_resp_i,
  output soc_pkg::bus_resp_t         resp_o
);

  import soc_pkg::*;

  target_e         tgt_q;  // Lines up with the stage 2 replies
  bus_resp_t       resp_d;
  logic            vld_q;
  logic            err_q;
  logic [XLEN-1:0] rdata_q;

  always_ff @(posedge clk_i, negedge anrst_i) begin
    if (!anrst_i) begin
      tgt_q <= TGT_RAM;
    end else begin
      tgt_q <= tgt_i;
    end
  end

  // ==================================================
  // Reply select
  // ==================================================
  always_comb begin
    resp_d = '0;
    case (tgt_q)
      TGT_RAM: begin
        resp_d.valid = ram_resp_i.valid;
        resp_d.rdata = ram_resp_i.rdata;
      end
      TGT_GPIO: begin
        resp_d.valid = gpio_resp_i.valid;
        resp_d.rdata = gpio_resp_i.rdata;
      end
      TGT_NONE: begin
        resp_d.valid = 1'b1;  // Nothing to wait for, answer with an error at once
        resp_d.err   = 1'b1;
      end
      default: resp_d = '0;
    endcase
  end

  always_ff @(posedge clk_i, negedge anrst_i) begin
    if (!anrst_i) begin
      vld_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      vld_q <= resp_d.valid;
      err_q <= resp_d.err;
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_q <= resp_d.rdata;
  end

  always_comb begin
    resp_o.valid = vld_q;
    resp_o.rdata = rdata_q;
    resp_o.err   = err_q;
  end

  // A reply from a peripheral that was not addressed would be lost
  a_reply_expected: assert property (@(posedge clk_i) disable iff (!anrst_i)
    (ram_resp_i.valid -> tgt_q == TGT_RAM) && (gpio_resp_i.valid -> tgt_q == TGT_GPIO));

endmodule

`default_nettype wire

// ==== soc_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module soc_top (
  input  wire logic                       clk_i,
  input  wire logic                       anrst_i,
  input  wire soc_pkg::bus_req_t          req_i,
  output soc_pkg::bus_resp_t              resp_o,
  input  wire logic [soc_pkg::GPIO_W-1:0] btn_i,
  output logic [soc_pkg::GPIO_W-1:0]      led_o,
  output logic                            irq_o,
  input  wire logic                       accept_i
);

  import soc_pkg::*;

  // ==================================================
  // Stage wiring
  // ==================================================
  periph_req_t  ram_req;   // Stage 1 to stage 2
  periph_req_t  gpio_req;
  target_e      tgt;       // Travels beside the requests to stage 3
  periph_resp_t ram_resp;  // Stage 2 to stage 3
  periph_resp_t gpio_resp;

  bus_decode i_bus_decode (
    .clk_i      (clk_i),
    .anrst_i    (anrst_i),
    .req_i      (req_i),
    .ram_req_o  (ram_req),
    .gpio_req_o (gpio_req),
    .tgt_o      (tgt)
  );

  data_ram i_data_ram (
    .clk_i   (clk_i),
    .anrst_i (anrst_i),
    .req_i   (ram_req),
    .resp_o  (ram_resp)
  );

  gpio_regs i_gpio_regs (
    .clk_i    (clk_i),
    .anrst_i  (anrst_i),
    .req_i    (gpio_req),
    .resp_o   (gpio_resp),
    .btn_i    (btn_i),
    .led_o    (led_o),
    .irq_o    (irq_o),
    .accept_i (accept_i)
  );

  resp_merge i_resp_merge (
    .clk_i       (clk_i),
    .anrst_i     (anrst_i),
    .tgt_i       (tgt),
    .ram_resp_i  (ram_resp),
    .gpio_resp_i (gpio_resp),
    .resp_o      (resp_o)
  );

endmodule

`default_nettype wire

// ==== tb_soc_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_soc_top;

  import soc_pkg::*;

  localparam int unsigned SEED     = 32'hd4c1_e2de;
  localparam int unsigned LATENCY  = 3;
  localparam int unsigned N_RND    = 32;
  localparam int unsigned MAX_POLL = 8;
  localparam int unsigned IRQ_WAIT = 16;
  // Worst case request count over all tests with five GPIO polls included
  localparam int unsigned N_REQ    = 3 + RAM_WORDS + 4 * N_RND + 11 + 9 + 8 + 5 * MAX_POLL;
  localparam int unsigned TIMEOUT  = 4 * N_REQ + 200;

  typedef struct packed {
    logic        chk;    // Polls only collect the data
    logic [31:0] cyc;    // Cycle in which the request was driven
    logic [31:0] rdata;
    logic        err;
  } exp_t;

  logic        clk_i;
  logic        anrst_i;
  bus_req_t    req;
  bus_resp_t   resp;
  logic [3:0]  btn;
  logic [3:0]  led;
  logic        irq;
  logic        accept;

  exp_t        exp_q[$];
  logic [31:0] cycle_cnt = '0;
  int unsigned errors;
  int unsigned checks;
  logic [31:0] last_rdata;

  // Reference state that is updated in request order
  logic [31:0] model_ram [RAM_WORDS];
  logic [3:0]  model_led;
  logic [3:0]  model_pend;
  logic [3:0]  model_en;

  soc_top i_soc_top (
    .clk_i    (clk_i),
    .anrst_i  (anrst_i),
    .req_i    (req),
    .resp_o   (resp),
    .btn_i    (btn),
    .led_o    (led),
    .irq_o    (irq),
    .accept_i (accept)
  );

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;  // 4 ns period

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  initial begin
    wait (cycle_cnt >= TIMEOUT);
    $display("timeout: the tests did not finish within %0d cycles", TIMEOUT);
    $display("SOME TESTS FAILED");
    $finish;
  end

  // ==================================================
  // Reference model and checking
  // ==================================================
  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  function automatic bus_resp_t ref_access(input bus_req_t r);
    bus_resp_t  res;
    logic [7:0] w;
    logic [1:0] off;
    int         b;
    res       = '0;
    res.valid = 1'b1;
    w         = r.addr[9:2];
    off       = r.addr[3:2];
    if ((r.addr & ~32'h0000_03ff) == RAM_BASE) begin  // 1 KiB window
      if (r.we) begin
        for (b = 0; b < 4; b++)
          if (r.be[b])
            model_ram[w][8*b +: 8] = r.wdata[8*b +: 8];
      end else begin
        res.rdata = model_ram[w];
      end
    end else if ((r.addr & ~32'h0000_000f) == GPIO_BASE) begin  // 16 byte window
      if (r.we) begin
        case (off)
          2'd0:    model_led = r.wdata[3:0];
          2'd2:    model_pend = model_pend & ~r.wdata[3:0];
          2'd3:    model_en = r.wdata[3:0];
          default: ;  // Button word is read only
        endcase
      end else begin
        case (off)
          2'd0:    res.rdata = {28'd0, model_led};
          2'd1:    res.rdata = {28'd0, btn};
          2'd2:    res.rdata = {28'd0, model_pend};
          default: res.rdata = {28'd0, model_en};
        endcase
      end
    end else begin
      res.err = 1'b1;
    end
    return res;
  endfunction

  // A request is driven half a cycle before the edge that samples it
  always @(negedge clk_i) begin
    if (anrst_i && resp.valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("a response arrived at %0t with no request outstanding", $time);
      end else begin
        last_rdata = resp.rdata;
        if (exp_q[0].chk) begin
          check_value("rdata", resp.rdata, exp_q[0].rdata);
          check_value("err", resp.err, exp_q[0].err);
        end
        check_value("latency", cycle_cnt - exp_q[0].cyc, LATENCY);
        void'(exp_q.pop_front());
      end
    end
  end

  // ==================================================
  // Stimulus tasks
  // ==================================================
  task automatic issue_req(input logic we, input logic [3:0] be, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic chk);
    bus_resp_t r;
    exp_t      e;
    @(negedge clk_i);
    req.valid = 1'b1;
    req.we    = we;
    req.be    = be;
    req.addr  = addr;
    req.wdata = wdata;
    r         = ref_access(req);
    e.chk     = chk;
    e.cyc     = cycle_cnt;
    e.rdata   = r.rdata;
    e.err     = r.err;
    exp_q.push_back(e);
  endtask

  task automatic drain_pipe();
    @(negedge clk_i);
    req = '0;
    while (exp_q.size() != 0)
      @(negedge clk_i);
  endtask

  task automatic poll_bits(input logic [1:0] off, input logic [3:0] mask, input string what);
    logic found;
    int   i;
    found = 1'b0;
    for (i = 0; i < MAX_POLL && !found; i++) begin
      issue_req(1'b0, 4'hf, GPIO_BASE | {off, 2'b00}, '0, 1'b0);
      drain_pipe();
      found = (last_rdata[3:0] & mask) == mask;
    end
    if (!found) begin
      errors++;
      $display("the %s never showed up in the GPIO register", what);
    end
  endtask

  task automatic wait_for_irq();
    int n;
    n = 0;
    while (!irq && n < IRQ_WAIT) begin
      @(negedge clk_i);
      n++;
    end
    if (!irq) begin
      errors++;
      $display("irq_o did not rise after an enabled button edge");
    end
  endtask

  task automatic pulse_accept();
    @(negedge clk_i);
    accept = 1'b1;
    @(negedge clk_i);
    accept     = 1'b0;
    model_pend = '0;
  endtask

  // ==================================================
  // Test sequence
  // ==================================================
  initial begin
    int unsigned i;
    logic [31:0] a;
    logic [31:0] d;
    errors     = 0;
    checks     = 0;
    last_rdata = '0;
    req        = '0;
    btn        = '0;
    accept     = 1'b0;
    anrst_i    = 1'b0;
    model_led  = '0;
    model_pend = '0;
    model_en   = '0;
    void'($urandom(SEED));
    repeat (10) @(negedge clk_i);
    anrst_i = 1'b1;

    check_value("resp_o.valid after reset", resp.valid, 0);
    check_value("irq_o after reset", irq, 0);
    check_value("led_o after reset", led, 0);
    issue_req(1'b0, 4'hf, GPIO_BASE + 32'h8, '0, 1'b1);
    issue_req(1'b0, 4'hf, GPIO_BASE + 32'hc, '0, 1'b1);
    issue_req(1'b0, 4'hf, GPIO_BASE, '0, 1'b1);
    drain_pipe();

    // Fill every word with a known value before the random traffic
    for (i = 0; i < RAM_WORDS; i++)
      issue_req(1'b1, 4'hf, RAM_BASE + (i << 2),
                {~i[7:0], i[7:0] ^ 8'h3c, i[7:0] + 8'h71, i[7:0]}, 1'b1);
    for (i = 0; i < N_RND; i++) begin
      a = RAM_BASE | ($urandom() & 32'h3ff);  // Low bits 1:0 random as well
      issue_req(1'b1, 4'($urandom()), a, $urandom(), 1'b1);
      issue_req(1'b0, 4'($urandom()), a, '0, 1'b1);  // Same word right after the write
    end
    for (i = 0; i < N_RND; i++)
      issue_req(1'b1, 4'($urandom()), RAM_BASE | ($urandom() & 32'h3ff), $urandom(), 1'b1);
    for (i = 0; i < N_RND; i++)
      issue_req(1'b0, 4'hf, RAM_BASE | ($urandom() & 32'h3ff), '0, 1'b1);
    drain_pipe();

    for (i = 0; i < 3; i++) begin
      d = $urandom();
      issue_req(1'b1, 4'hf, GPIO_BASE, d, 1'b1);
      issue_req(1'b0, 4'hf, GPIO_BASE, '0, 1'b1);
      drain_pipe();
      check_value("led_o", led, model_led);
    end
    btn = 4'b1010;
    issue_req(1'b1, 4'hf, GPIO_BASE + 32'h4, 32'hf, 1'b1);
    poll_bits(2'd1, 4'b1010, "button value");
    issue_req(1'b0, 4'hf, GPIO_BASE + 32'h4, '0, 1'b1);
    poll_bits(2'd2, 4'b1010, "pending bits of buttons 1 and 3");
    model_pend = model_pend | 4'b1010;
    issue_req(1'b0, 4'hf, GPIO_BASE + 32'h8, '0, 1'b1);
    issue_req(1'b1, 4'hf, GPIO_BASE + 32'h8, 32'ha, 1'b1);
    issue_req(1'b0, 4'hf, GPIO_BASE + 32'h8, '0, 1'b1);
    drain_pipe();
    check_value("irq_o with mask clear", irq, 0);
    btn = 4'b0000;

    // Unmapped and aliased addresses must not touch RAM or GPIO
    issue_req(1'b1, 4'hf, RAM_BASE + 32'h400, 32'h1234_5678, 1'b1);
    issue_req(1'b1, 4'hf, GPIO_BASE + 32'h10, 32'hf, 1'b1);
    issue_req(1'b1, 4'hf, GPIO_BASE + 32'h1c, 32'hf, 1'b1);
    issue_req(1'b1, 4'hf, 32'h0, 32'hffff_ffff, 1'b1);
    issue_req(1'b0, 4'hf, RAM_BASE - 32'h4, '0, 1'b1);
    issue_req(1'b0, 4'hf, GPIO_BASE + 32'h20, '0, 1'b1);
    issue_req(1'b0, 4'hf, RAM_BASE, '0, 1'b1);
    issue_req(1'b0, 4'hf, GPIO_BASE, '0, 1'b1);
    issue_req(1'b0, 4'hf, GPIO_BASE + 32'hc, '0, 1'b1);
    drain_pipe();

    issue_req(1'b1, 4'hf, GPIO_BASE + 32'hc, 32'h1, 1'b1);
    drain_pipe();
    btn = 4'b0001;
    wait_for_irq();
    poll_bits(2'd2, 4'b0001, "pending bit of button 0");
    model_pend = model_pend | 4'b0001;
    issue_req(1'b0, 4'hf, GPIO_BASE + 32'h8, '0, 1'b1);
    issue_req(1'b1, 4'hf, GPIO_BASE + 32'h8, 32'h1, 1'b1);
    issue_req(1'b0, 4'hf, GPIO_BASE + 32'h8, '0, 1'b1);
    drain_pipe();
    check_value("irq_o after write to clear", irq, 0);

    issue_req(1'b1, 4'hf, GPIO_BASE + 32'hc, 32'hf, 1'b1);
    drain_pipe();
    btn = 4'b1111;
    wait_for_irq();
    poll_bits(2'd2, 4'b1110, "pending bits of buttons 1 to 3");
    model_pend = model_pend | 4'b1110;
    pulse_accept();
    check_value("irq_o after accept", irq, 0);
    issue_req(1'b0, 4'hf, GPIO_BASE + 32'h8, '0, 1'b1);
    btn = 4'b0000;
    drain_pipe();

    issue_req(1'b1, 4'hf, GPIO_BASE + 32'hc, 32'h0, 1'b1);
    drain_pipe();
    btn = 4'b0001;
    poll_bits(2'd2, 4'b0001, "pending bit with the interrupt disabled");
    model_pend = model_pend | 4'b0001;
    check_value("irq_o with enable clear", irq, 0);
    issue_req(1'b0, 4'hf, GPIO_BASE + 32'h8, '0, 1'b1);
    drain_pipe();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
soc_pkg.sv
bus_decode.sv
data_ram.sv
gpio_regs.sv
resp_merge.sv
soc_top.sv
tb_soc_top.sv

// ==== Bender.yml ====
package:
  name: soc_periph

sources:
  - soc_pkg.sv
  - bus_decode.sv
  - data_ram.sv
  - gpio_regs.sv
  - resp_merge.sv
  - soc_top.sv
  - target: test
    files:
      - tb_soc_top.sv
